/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_modexp
FILELIST  = tb.f
BUILD_DIR = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, look for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

/* src/modexp_cfg_regs.sv */
`timescale 1ns/100ps

module modexp_cfg_regs
(
	input  logic                                clk,
	input  logic                                rst,
	input  logic                                cfg_we,
	input  logic                                cfg_re,
	input  logic [modexp_regs_pkg::ADDR_W-1:0]  cfg_addr,
	input  logic [modexp_regs_pkg::REG_W-1:0]   cfg_wdata,
	output logic [modexp_regs_pkg::REG_W-1:0]   cfg_rdata,
	input  logic                                busy,
	input  logic                                done_pulse,
	output logic [modexp_pkg::OPW-1:0]          modulus
);

	// modulus register, read live by the engine
	logic [modexp_pkg::OPW-1:0] mod_r;
	// completed operation count
	logic [modexp_regs_pkg::REG_W-1:0] done_cnt;
	// status word, busy in bit 0
	logic [modexp_regs_pkg::REG_W-1:0] status_w;

	assign modulus = mod_r;
	assign status_w = {{(modexp_regs_pkg::REG_W-1){1'b0}}, busy};

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			mod_r <= modexp_regs_pkg::MODULUS_RST;
			done_cnt <= '0;
			cfg_rdata <= '0;
		end
		else
		begin
			// modulus must not move under a running operation
			if (cfg_we && !busy && (cfg_addr == modexp_regs_pkg::ADDR_MODULUS))
			begin
				mod_r <= cfg_wdata;
			end

			// one pulse per result taken, wraps at 16 bits
			if (done_pulse)
			begin
				done_cnt <= done_cnt + 1'b1;
			end

			// read data lands one cycle after cfg_re and holds
			if (cfg_re)
			begin
				case (cfg_addr)
					modexp_regs_pkg::ADDR_MODULUS: cfg_rdata <= mod_r;
					modexp_regs_pkg::ADDR_STATUS: cfg_rdata <= status_w;
					modexp_regs_pkg::ADDR_DONECNT: cfg_rdata <= done_cnt;
					// unmapped reads as zero
					default: cfg_rdata <= '0;
				endcase
			end
		end
	end

endmodule

/* src/modexp_engine.sv */
`timescale 1ns/100ps

module modexp_engine
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       in_valid,
	output logic                       in_ready,
	input  logic [modexp_pkg::OPW-1:0] in_m,
	input  logic [modexp_pkg::OPW-1:0] in_e,
	output logic                       out_valid,
	input  logic                       out_ready,
	output logic [modexp_pkg::OPW-1:0] out_c,
	input  logic [modexp_pkg::OPW-1:0] modulus,
	output logic                       busy,
	output logic                       done_pulse
);

	// control
	logic [modexp_pkg::STATE_W-1:0] state;
	// exponent bits consumed so far
	logic [modexp_pkg::BITCNT_W-1:0] bitcnt;
	logic first_one;
	logic mm_start;
	logic last_bit;

	// result, shifting exponent and latched base
	logic [modexp_pkg::OPW-1:0] creg;
	logic [modexp_pkg::OPW-1:0] ereg;
	logic [modexp_pkg::OPW-1:0] mreg;
	logic [modexp_pkg::OPW-1:0] one_mod_n;

	// multiplier side
	logic [modexp_pkg::OPW-1:0] mm_a;
	logic [modexp_pkg::OPW-1:0] mm_b;
	logic [modexp_pkg::OPW-1:0] mm_n;
	logic [modexp_pkg::OPW-1:0] mm_p;
	logic mm_done;

	assign in_ready = (state == modexp_pkg::ST_IDLE);
	assign out_valid = (state == modexp_pkg::ST_HOLD);
	assign out_c = creg;
	assign busy = !in_ready;
	assign done_pulse = out_valid && out_ready;

	// the bit now leaving ereg is the lowest one
	assign last_bit = (bitcnt == modexp_pkg::BIT_LAST);
	// 1 mod n, zero only when n is 1
	assign one_mod_n = {{(modexp_pkg::OPW-1){1'b0}}, |modulus[modexp_pkg::OPW-1:1]};

	// square uses result twice, multiply takes m as second operand
	assign mm_a = creg;
	assign mm_b = (state == modexp_pkg::ST_MULT) ? mreg : creg;
	// modulus is frozen by the register block while busy
	assign mm_n = modulus;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= modexp_pkg::ST_IDLE;
			bitcnt <= '0;
			first_one <= 1'b0;
			mm_start <= 1'b0;
		end
		else
		begin
			mm_start <= 1'b0;
			case (state)
				modexp_pkg::ST_IDLE:
					if (in_valid)
					begin
						bitcnt <= '0;
						first_one <= 1'b0;
						// zero exponent, nothing to scan
						state <= (in_e == '0) ? modexp_pkg::ST_HOLD : modexp_pkg::ST_SCAN;
					end
				modexp_pkg::ST_SCAN:
					if (first_one)
					begin
						// top one was also the lowest bit
						if (bitcnt == modexp_pkg::BIT_END)
						begin
							state <= modexp_pkg::ST_HOLD;
						end
						else
						begin
							state <= modexp_pkg::ST_SQUARE;
							mm_start <= 1'b1;
						end
					end
					else
					begin
						bitcnt <= bitcnt + 1'b1;
						first_one <= ereg[modexp_pkg::OPW-1];
					end
				modexp_pkg::ST_SQUARE:
					if (mm_done)
					begin
						if (ereg[modexp_pkg::OPW-1])
						begin
							state <= modexp_pkg::ST_MULT;
							mm_start <= 1'b1;
						end
						else
						begin
							// zero bit, square only
							bitcnt <= bitcnt + 1'b1;
							state <= last_bit ? modexp_pkg::ST_HOLD : modexp_pkg::ST_SQUARE;
							mm_start <= !last_bit;
						end
					end
				modexp_pkg::ST_MULT:
					if (mm_done)
					begin
						bitcnt <= bitcnt + 1'b1;
						state <= last_bit ? modexp_pkg::ST_HOLD : modexp_pkg::ST_SQUARE;
						mm_start <= !last_bit;
					end
				modexp_pkg::ST_HOLD:
					// back-pressure keeps us here with in_ready low
					if (out_ready)
					begin
						state <= modexp_pkg::ST_IDLE;
					end
				default:
					state <= modexp_pkg::ST_IDLE;
			endcase
		end
	end

	// datapath follows the fsm
	always_ff @(posedge clk)
	begin
		case (state)
			modexp_pkg::ST_IDLE:
				if (in_valid)
				begin
					mreg <= in_m;
					ereg <= in_e;
					// final value for e == 0, overwritten otherwise
					creg <= one_mod_n;
				end
			modexp_pkg::ST_SCAN:
				if (!first_one)
				begin
					ereg <= {ereg[modexp_pkg::OPW-2:0], 1'b0};
					// first one loads m, no multiply needed
					if (ereg[modexp_pkg::OPW-1])
					begin
						creg <= mreg;
					end
				end
			modexp_pkg::ST_SQUARE:
				if (mm_done)
				begin
					creg <= mm_p;
					// set bit stays on top for the multiply
					if (!ereg[modexp_pkg::OPW-1])
					begin
						ereg <= {ereg[modexp_pkg::OPW-2:0], 1'b0};
					end
				end
			modexp_pkg::ST_MULT:
				if (mm_done)
				begin
					creg <= mm_p;
					ereg <= {ereg[modexp_pkg::OPW-2:0], 1'b0};
				end
			default:
				begin
				end
		endcase
	end

	modmult_serial mult_i
	(
		.clk   (clk),
		.rst   (rst),
		.start (mm_start),
		.a     (mm_a),
		.b     (mm_b),
		.n     (mm_n),
		.done  (mm_done),
		.p     (mm_p)
	);

endmodule

/* src/modexp_pkg.sv */
package modexp_pkg;

	// operand width for m, e, n and c
	localparam int OPW = 16;

	// exponent and multiplier bit counters, must reach OPW
	localparam int BITCNT_W = 5;

	// start sample to done, one cycle per bit plus the done cycle
	localparam int LAT_MULT = OPW + 1;

	// counter values the controllers compare against
	localparam logic [BITCNT_W-1:0] BIT_LAST = BITCNT_W'(OPW - 1);
	localparam logic [BITCNT_W-1:0] BIT_END = BITCNT_W'(OPW);
	localparam logic [BITCNT_W-1:0] MULT_END = BITCNT_W'(LAT_MULT - 1);

	// engine fsm encoding
	localparam int STATE_W = 3;
	localparam logic [STATE_W-1:0] ST_IDLE = 3'd0;
	// shift off leading zeros, then dispatch
	localparam logic [STATE_W-1:0] ST_SCAN = 3'd1;
	localparam logic [STATE_W-1:0] ST_SQUARE = 3'd2;
	localparam logic [STATE_W-1:0] ST_MULT = 3'd3;
	// result presented, waiting for out_ready
	localparam logic [STATE_W-1:0] ST_HOLD = 3'd4;

endpackage

/* src/modexp_regs_pkg.sv */
package modexp_regs_pkg;

	// configuration bus widths
	localparam int REG_W = 16;
	localparam int ADDR_W = 2;

	// register map
	// modulus, read/write, writes dropped while busy
	localparam logic [ADDR_W-1:0] ADDR_MODULUS = 2'd0;
	// bit 0 busy, rest zero
	localparam logic [ADDR_W-1:0] ADDR_STATUS = 2'd1;
	// results delivered, wraps
	localparam logic [ADDR_W-1:0] ADDR_DONECNT = 2'd2;

	// modulus after reset, an odd prime
	localparam logic [REG_W-1:0] MODULUS_RST = 16'hFFF1;

endpackage

/* src/modexp_top.sv */
`timescale 1ns/100ps

module modexp_top
(
	input  logic                               clk,
	input  logic                               rst,
	// operand port
	input  logic                               in_valid,
	output logic                               in_ready,
	input  logic [modexp_pkg::OPW-1:0]         in_m,
	input  logic [modexp_pkg::OPW-1:0]         in_e,
	// result port
	output logic                               out_valid,
	input  logic                               out_ready,
	output logic [modexp_pkg::OPW-1:0]         out_c,
	// configuration port
	input  logic                               cfg_we,
	input  logic                               cfg_re,
	input  logic [modexp_regs_pkg::ADDR_W-1:0] cfg_addr,
	input  logic [modexp_regs_pkg::REG_W-1:0]  cfg_wdata,
	output logic [modexp_regs_pkg::REG_W-1:0]  cfg_rdata
);

	// between register block and engine
	logic [modexp_pkg::OPW-1:0] modulus;
	logic busy;
	logic done_pulse;

	modexp_cfg_regs cfg_regs_i
	(
		.clk        (clk),
		.rst        (rst),
		.cfg_we     (cfg_we),
		.cfg_re     (cfg_re),
		.cfg_addr   (cfg_addr),
		.cfg_wdata  (cfg_wdata),
		.cfg_rdata  (cfg_rdata),
		.busy       (busy),
		.done_pulse (done_pulse),
		.modulus    (modulus)
	);

	modexp_engine engine_i
	(
		.clk        (clk),
		.rst        (rst),
		.in_valid   (in_valid),
		.in_ready   (in_ready),
		.in_m       (in_m),
		.in_e       (in_e),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_c      (out_c),
		.modulus    (modulus),
		.busy       (busy),
		.done_pulse (done_pulse)
	);

endmodule

/* src/modmult_serial.sv */
`timescale 1ns/100ps

module modmult_serial
(
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       start,
	input  logic [modexp_pkg::OPW-1:0] a,
	input  logic [modexp_pkg::OPW-1:0] b,
	input  logic [modexp_pkg::OPW-1:0] n,
	output logic                       done,
	output logic [modexp_pkg::OPW-1:0] p
);

	// control
	logic run;
	logic [modexp_pkg::BITCNT_W-1:0] cnt;

	// operands captured on the start edge
	logic [modexp_pkg::OPW-1:0] a_r;
	logic [modexp_pkg::OPW-1:0] b_r;
	logic [modexp_pkg::OPW-1:0] n_r;

	// accumulator with one spare bit
	logic [modexp_pkg::OPW:0] acc;

	// one interleaved step, 2*acc + a can reach 3n so two more bits
	logic [modexp_pkg::OPW+1:0] t_add;
	logic [modexp_pkg::OPW+1:0] t_sub1;
	logic [modexp_pkg::OPW+1:0] t_sub2;
	logic [modexp_pkg::OPW+1:0] n_ext;

	assign n_ext = {2'b00, n_r};
	// msb of b first
	assign t_add = {acc, 1'b0} + (b_r[modexp_pkg::OPW-1] ? {2'b00, a_r} : '0);
	// at most two subtractions bring it back below n
	assign t_sub1 = (t_add >= n_ext) ? (t_add - n_ext) : t_add;
	assign t_sub2 = (t_sub1 >= n_ext) ? (t_sub1 - n_ext) : t_sub1;

	// acc stays put after the last step, so p holds through done
	assign p = acc[modexp_pkg::OPW-1:0];

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			run <= 1'b0;
			cnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				run <= 1'b1;
				cnt <= '0;
			end
			else if (run)
			begin
				// OPW steps, then one cycle to flag done
				if (cnt == modexp_pkg::MULT_END)
				begin
					run <= 1'b0;
					done <= 1'b1;
				end
				else
				begin
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// datapath
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			a_r <= a;
			b_r <= b;
			n_r <= n;
			acc <= '0;
		end
		else if (run && (cnt != modexp_pkg::MULT_END))
		begin
			acc <= t_sub2[modexp_pkg::OPW:0];
			b_r <= {b_r[modexp_pkg::OPW-2:0], 1'b0};
		end
	end

endmodule

/* tb.f */
src/modexp_pkg.sv
src/modexp_regs_pkg.sv
src/modmult_serial.sv
src/modexp_cfg_regs.sv
src/modexp_engine.sv
src/modexp_top.sv
testbench/modexp_sva.sv
testbench/tb_modexp.sv

/* testbench/modexp_sva.sv */
`timescale 1ns/100ps

module modexp_sva
(
	input logic                       clk,
	input logic                       rst,
	input logic                       in_valid,
	input logic                       in_ready,
	input logic                       out_valid,
	input logic                       out_ready,
	input logic [modexp_pkg::OPW-1:0] out_c,
	input logic [modexp_pkg::OPW-1:0] modulus
);

	// count of assertion failures
	int fail_cnt = 0;

	// stalled result stays put until taken
	property p_hold_stable;
		@(posedge clk) disable iff (rst)
		(out_valid && !out_ready) |=> (out_valid && $stable(out_c));
	endproperty

	// one operation in flight at most, an accepted operand drops in_ready
	property p_accept_busy;
		@(posedge clk) disable iff (rst)
		(in_valid && in_ready) |=> !in_ready;
	endproperty

	// result already reduced
	property p_result_range;
		@(posedge clk) disable iff (rst)
		out_valid |-> (out_c < modulus);
	endproperty

	a_hold_stable: assert property (p_hold_stable)
		else
		begin
			$error("out_valid or out_c changed while out_ready was low");
			fail_cnt++;
		end
	a_accept_busy: assert property (p_accept_busy)
		else
		begin
			$error("in_ready still high after an operand was accepted");
			fail_cnt++;
		end
	a_result_range: assert property (p_result_range)
		else
		begin
			$error("out_c not below modulus");
			fail_cnt++;
		end

endmodule

bind modexp_engine modexp_sva sva_i
(
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_ready (out_ready),
	.out_c     (out_c),
	.modulus   (modulus)
);

/* testbench/tb_modexp.sv */
`timescale 1ns/100ps

module tb_modexp;

	// ops issued: 4 fixed, 40 random, 1 with a write while busy
	localparam int NUM_OPS = 45;
	// every bit squared and multiplied, plus the scan
	localparam int WORST_CYC = 2 * modexp_pkg::OPW * modexp_pkg::LAT_MULT + modexp_pkg::OPW;
	// doubled for back-pressure stalls, plus register traffic
	localparam int TIMEOUT_CYC = NUM_OPS * WORST_CYC * 2 + 2000;

	logic clk;
	logic rst;
	logic in_valid;
	logic in_ready;
	logic [modexp_pkg::OPW-1:0] in_m;
	logic [modexp_pkg::OPW-1:0] in_e;
	logic out_valid;
	logic out_ready;
	logic [modexp_pkg::OPW-1:0] out_c;
	logic cfg_we;
	logic cfg_re;
	logic [modexp_regs_pkg::ADDR_W-1:0] cfg_addr;
	logic [modexp_regs_pkg::REG_W-1:0] cfg_wdata;
	logic [modexp_regs_pkg::REG_W-1:0] cfg_rdata;

	// expected results in issue order
	logic [15:0] exp_q[$];
	string name_q[$];
	int errors;
	int sent;
	int taken;
	int cycles;
	integer seed;
	// random out_ready stalls when set
	logic bp_en;
	// modulus the DUT should be using
	logic [15:0] cur_mod;
	logic [15:0] rd;
	logic [15:0] m_v;
	logic [15:0] e_v;
	logic [15:0] mod_list[5];

	modexp_top modexp_top_i
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_m      (in_m),
		.in_e      (in_e),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_c     (out_c),
		.cfg_we    (cfg_we),
		.cfg_re    (cfg_re),
		.cfg_addr  (cfg_addr),
		.cfg_wdata (cfg_wdata),
		.cfg_rdata (cfg_rdata)
	);

	always #4 clk = ~clk;

	// plain square-and-multiply, reduce after every step
	function automatic logic [15:0] ref_modexp(input logic [15:0] m, input logic [15:0] e,
		input logic [15:0] n);
		logic [31:0] r;
		logic [31:0] base;
		logic [31:0] n32;
		int i;
		n32 = {16'h0, n};
		base = {16'h0, m} % n32;
		r = 32'd1 % n32;
		for (i = modexp_pkg::OPW - 1; i >= 0; i--)
		begin
			r = (r * r) % n32;
			if (e[i])
				r = (r * base) % n32;
		end
		return r[15:0];
	endfunction

	task automatic check(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (expected !== actual)
		begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic cfg_write(input logic [modexp_regs_pkg::ADDR_W-1:0] addr,
		input logic [15:0] data);
		@(posedge clk);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
	endtask

	// data sampled at the negedge after the read edge
	task automatic cfg_read(input logic [modexp_regs_pkg::ADDR_W-1:0] addr,
		output logic [15:0] data);
		@(posedge clk);
		cfg_re <= 1'b1;
		cfg_addr <= addr;
		@(posedge clk);
		cfg_re <= 1'b0;
		@(negedge clk);
		data = cfg_rdata;
	endtask

	// queue expectation, then hold valid until accepted
	task automatic send_op(input logic [15:0] m, input logic [15:0] e, input string name);
		exp_q.push_back(ref_modexp(m, e, cur_mod));
		name_q.push_back(name);
		sent++;
		@(posedge clk);
		in_valid <= 1'b1;
		in_m <= m;
		in_e <= e;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		// transfer edge
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		while (taken != sent)
			@(negedge clk);
	endtask

	// back-pressure source, about one cycle in four stalled
	always @(posedge clk)
		out_ready <= bp_en ? (($random(seed) & 3) != 0) : 1'b1;

	// comparing process, result taken on the next posedge
	initial
	begin
		forever
		begin
			@(negedge clk);
			if (out_valid && out_ready)
			begin
				if (exp_q.size() == 0)
				begin
					$display("result %0h delivered with no operation pending", out_c);
					errors++;
				end
				else
				begin
					check(name_q.pop_front(), exp_q.pop_front(), out_c);
				end
				taken++;
			end
		end
	end

	// hang guard
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYC)
		begin
			$display("timeout after %0d cycles, results taken %0d of %0d", cycles, taken, sent);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		in_m = '0;
		in_e = '0;
		out_ready = 1'b0;
		cfg_we = 1'b0;
		cfg_re = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		errors = 0;
		sent = 0;
		taken = 0;
		cycles = 0;
		seed = 49944;
		bp_en = 1'b0;
		cur_mod = modexp_regs_pkg::MODULUS_RST;
		// 251 is an odd prime, 2 the smallest legal modulus
		mod_list[0] = 16'd2;
		mod_list[1] = 16'd251;
		mod_list[2] = 16'd1000;
		mod_list[3] = 16'hFFFF;
		mod_list[4] = 16'd3;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// reset values
		cfg_read(modexp_regs_pkg::ADDR_MODULUS, rd);
		check("modulus_reset", modexp_regs_pkg::MODULUS_RST, rd);
		cfg_read(modexp_regs_pkg::ADDR_STATUS, rd);
		check("status_reset", 16'd0, rd);

		// fixed cases on the default modulus
		send_op(16'h1234, 16'h0000, "fixed_e0");
		send_op(16'h1234, 16'h0001, "fixed_e1");
		send_op(16'hBEEF, 16'hFFFF, "fixed_effff");
		send_op(16'h0000, 16'h0123, "fixed_m0");
		wait_drain();

		// write while busy is dropped, status shows busy
		send_op(16'h1357, 16'hA5A5, "busy_write");
		cfg_write(modexp_regs_pkg::ADDR_MODULUS, 16'd257);
		cfg_read(modexp_regs_pkg::ADDR_MODULUS, rd);
		check("modulus_while_busy", cur_mod, rd);
		cfg_read(modexp_regs_pkg::ADDR_STATUS, rd);
		check("status_busy", 16'd1, rd);
		wait_drain();

		// random operands, new modulus per group, stalls on
		bp_en = 1'b1;
		for (int k = 0; k < 5; k++)
		begin
			wait_drain();
			cfg_write(modexp_regs_pkg::ADDR_MODULUS, mod_list[k]);
			cur_mod = mod_list[k];
			cfg_read(modexp_regs_pkg::ADDR_MODULUS, rd);
			check($sformatf("modulus_write_%0d", k), cur_mod, rd);
			for (int j = 0; j < 8; j++)
			begin
				m_v = 16'(($random(seed) & 32'h7fffffff) % {16'h0, cur_mod});
				// vary exponent length too
				e_v = 16'($random(seed)) >> (($random(seed) & 32'h7fffffff) % 16);
				send_op(m_v, e_v, $sformatf("rand_n%0d_%0d", cur_mod, j));
			end
		end
		wait_drain();
		bp_en = 1'b0;

		// status and completion count
		cfg_read(modexp_regs_pkg::ADDR_STATUS, rd);
		check("status_idle", 16'd0, rd);
		cfg_read(modexp_regs_pkg::ADDR_DONECNT, rd);
		check("done_count", 16'(taken), rd);
		if (sent != taken || exp_q.size() != 0)
		begin
			$display("results lost or duplicated, sent %0d taken %0d", sent, taken);
			errors++;
		end

		// failures of the bound assertions
		errors += modexp_top_i.engine_i.sva_i.fail_cnt;

		$display("errors %0d, results sent %0d, results taken %0d", errors, sent, taken);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
